// ==== verilog/fe_pkg.sv ====
// fetch back end shared definitions
// widths, output queue sizing and halfword helpers for the realigner

package fe_pkg;

  // address and instruction widths
  localparam int vaddr_width  = 32;
  localparam int instr_width  = 32;
  localparam int cinstr_width = 16;

  // output queue sizing
  localparam int queue_depth     = 4;
  localparam int queue_ptr_width = $clog2(queue_depth);

  // a halfword opens a compressed instruction unless both low bits are set
  function automatic logic hw_compressed(input logic [cinstr_width-1:0] hw);
    return ~&hw[1:0];
  endfunction

  // pick the lower (0) or upper (1) halfword of a fetch word
  function automatic logic [cinstr_width-1:0] hw_select(
    input logic [instr_width-1:0] word,
    input logic                   upper
  );
    return upper ? word[cinstr_width +: cinstr_width] : word[0 +: cinstr_width];
  endfunction

endpackage

// ==== verilog/fe_word_capture.sv ====
// fetch word capture
// four-phase req/ack receiver holding one fetch word for the realigner
// a full word register shows up on the memory side as a late ack

`timescale 1ns/1ps

module fe_word_capture (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // memory side, four-phase
  input  logic                            fetch_req_i,
  input  logic [fe_pkg::vaddr_width-1:0]  fetch_pc_i,
  input  logic [fe_pkg::instr_width-1:0]  fetch_data_i,
  output logic                            fetch_ack_o,

  // redirect drops the held word
  input  logic                            redirect_v_i,

  // realigner side
  output logic                            word_v_o,
  output logic [fe_pkg::vaddr_width-1:0]  word_pc_o,
  output logic [fe_pkg::instr_width-1:0]  word_data_o,
  input  logic                            word_yumi_i
);

  logic                           ack_r;
  logic                           word_v_r;
  logic [fe_pkg::vaddr_width-1:0] word_pc_r;
  logic [fe_pkg::instr_width-1:0] word_data_r;
  logic                           accept;

  // new request, previous ack already returned, room in the register
  // a redirect cycle never takes a word
  assign accept = fetch_req_i & ~ack_r & ~word_v_r & ~redirect_v_i;

  // ack follows req, drops one cycle after req goes low
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_r <= 1'b0;
    end else if (accept) begin
      ack_r <= 1'b1;
    end else if (ack_r && !fetch_req_i) begin
      ack_r <= 1'b0;
    end
  end

  // word register occupancy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      word_v_r <= 1'b0;
    end else if (redirect_v_i || word_yumi_i) begin
      word_v_r <= 1'b0;
    end else if (accept) begin
      word_v_r <= 1'b1;
    end
  end

  // payload, data is stable while req is high
  always_ff @(posedge clk_i) begin
    if (accept) begin
      word_pc_r   <= fetch_pc_i;
      word_data_r <= fetch_data_i;
    end
  end

  assign fetch_ack_o = ack_r;
  assign word_v_o    = word_v_r;
  assign word_pc_o   = word_pc_r;
  assign word_data_o = word_data_r;

endmodule

// ==== verilog/fe_realigner.sv ====
// instruction realigner
// splits fetch words into 16 and 32 bit instructions and joins a
// 32-bit instruction that starts in the upper half of one word with
// the lower half of the next

`timescale 1ns/1ps

module fe_realigner (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // held fetch word from capture
  input  logic                            word_v_i,
  input  logic [fe_pkg::vaddr_width-1:0]  word_pc_i,
  input  logic [fe_pkg::instr_width-1:0]  word_data_i,
  output logic                            word_yumi_o,

  // redirect clears the pending half
  input  logic                            redirect_v_i,

  // rebuilt instruction to the queue
  output logic                            instr_v_o,
  output logic [fe_pkg::instr_width-1:0]  instr_o,
  output logic [fe_pkg::vaddr_width-1:0]  instr_pc_o,
  output logic                            instr_compressed_o,
  input  logic                            queue_ready_i
);

  localparam int pad_width = fe_pkg::instr_width - fe_pkg::cinstr_width;

  // position within the current word, set once the lower half is used
  logic half_r;

  // partial instruction waiting for its second half
  logic                            pend_v_r;
  logic [fe_pkg::cinstr_width-1:0] pend_hw_r;
  logic [fe_pkg::vaddr_width-1:0]  pend_pc_r;

  logic                            eff_half;
  logic [fe_pkg::cinstr_width-1:0] lower_hw;
  logic [fe_pkg::cinstr_width-1:0] upper_hw;
  logic                            lower_c;
  logic                            upper_c;
  logic [fe_pkg::vaddr_width-1:0]  lower_pc;
  logic [fe_pkg::vaddr_width-1:0]  upper_pc;

  logic                            emit_v;
  logic                            emit_last;
  logic                            store_v;
  logic                            store_go;
  logic                            fire;

  assign lower_hw = fe_pkg::hw_select(word_data_i, 1'b0);
  assign upper_hw = fe_pkg::hw_select(word_data_i, 1'b1);
  assign lower_c  = fe_pkg::hw_compressed(lower_hw);
  assign upper_c  = fe_pkg::hw_compressed(upper_hw);

  // halfword addresses inside the word
  assign lower_pc = {word_pc_i[fe_pkg::vaddr_width-1:2], 2'b00};
  assign upper_pc = {word_pc_i[fe_pkg::vaddr_width-1:2], 2'b10};

  // misaligned entry skips the lower half from the start
  assign eff_half = word_pc_i[1] | half_r;

  // case split, one instruction per cycle at most
  always_comb begin
    emit_v             = 1'b0;
    emit_last          = 1'b0;
    store_v            = 1'b0;
    instr_o            = word_data_i;
    instr_pc_o         = lower_pc;
    instr_compressed_o = 1'b0;
    if (word_v_i) begin
      if (pend_v_r) begin
        // finish the straddling instruction, upper half comes next
        emit_v     = 1'b1;
        instr_o    = {lower_hw, pend_hw_r};
        instr_pc_o = pend_pc_r;
      end else if (!eff_half) begin
        emit_v     = 1'b1;
        instr_pc_o = lower_pc;
        if (lower_c) begin
          instr_o            = {{pad_width{1'b0}}, lower_hw};
          instr_compressed_o = 1'b1;
        end else begin
          // aligned full instruction uses the whole word
          instr_o   = word_data_i;
          emit_last = 1'b1;
        end
      end else if (upper_c) begin
        emit_v             = 1'b1;
        emit_last          = 1'b1;
        instr_o            = {{pad_width{1'b0}}, upper_hw};
        instr_pc_o         = upper_pc;
        instr_compressed_o = 1'b1;
      end else begin
        // upper half opens a full instruction, park it
        store_v = 1'b1;
      end
    end
  end

  // a redirect squashes whatever the held word would produce
  assign instr_v_o   = emit_v & ~redirect_v_i;
  assign fire        = instr_v_o & queue_ready_i;
  assign store_go    = store_v & ~redirect_v_i;
  assign word_yumi_o = store_go | (fire & emit_last);

  // control state
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      half_r   <= 1'b0;
      pend_v_r <= 1'b0;
    end else if (redirect_v_i) begin
      half_r   <= 1'b0;
      pend_v_r <= 1'b0;
    end else begin
      // back to the lower half for each new word
      if (word_yumi_o) begin
        half_r <= 1'b0;
      end else if (fire) begin
        half_r <= 1'b1;
      end
      if (store_go) begin
        pend_v_r <= 1'b1;
      end else if (fire && pend_v_r) begin
        pend_v_r <= 1'b0;
      end
    end
  end

  // parked upper half and its address
  always_ff @(posedge clk_i) begin
    if (store_go) begin
      pend_hw_r <= upper_hw;
      pend_pc_r <= upper_pc;
    end
  end

endmodule

// ==== verilog/fe_instr_queue.sv ====
// instruction output queue
// circular FIFO of rebuilt instructions, head entry offered to decode
// over a four-phase req/ack sender

`timescale 1ns/1ps

module fe_instr_queue (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // push side from the realigner
  input  logic                            instr_v_i,
  input  logic [fe_pkg::instr_width-1:0]  instr_i,
  input  logic [fe_pkg::vaddr_width-1:0]  instr_pc_i,
  input  logic                            instr_compressed_i,
  output logic                            queue_ready_o,

  // decode side, four-phase
  output logic                            instr_req_o,
  output logic [fe_pkg::instr_width-1:0]  instr_o,
  output logic [fe_pkg::vaddr_width-1:0]  instr_pc_o,
  output logic                            instr_compressed_o,
  input  logic                            instr_ack_i
);

  localparam int depth = fe_pkg::queue_depth;

  typedef enum logic [1:0] {
    s_idle,
    s_req,
    s_wait
  } send_state_e;

  send_state_e state_r;

  logic [fe_pkg::instr_width-1:0]     mem_instr [depth];
  logic [fe_pkg::vaddr_width-1:0]     mem_pc    [depth];
  logic                               mem_c     [depth];

  logic [fe_pkg::queue_ptr_width-1:0] wr_ptr_r;
  logic [fe_pkg::queue_ptr_width-1:0] rd_ptr_r;
  logic [fe_pkg::queue_ptr_width:0]   count_r;
  logic                               push;
  logic                               pop;
  logic                               head_c;

  // pop on ack lets a full queue still take a push that cycle
  assign pop           = (state_r == s_req) & instr_ack_i;
  assign queue_ready_o = (count_r != depth[fe_pkg::queue_ptr_width:0]) | pop;
  assign push          = instr_v_i & queue_ready_o;

  // entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_instr[wr_ptr_r] <= instr_i;
      mem_pc[wr_ptr_r]    <= instr_pc_i;
      mem_c[wr_ptr_r]     <= instr_compressed_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == depth - 1) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == depth - 1) ? '0 : rd_ptr_r + 1'b1;
      end
      if (push && !pop) begin
        count_r <= count_r + 1'b1;
      end else if (pop && !push) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  // four-phase sender waits for ack low between transfers
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= s_idle;
    end else begin
      case (state_r)
        s_idle: if (count_r != '0 && !instr_ack_i) state_r <= s_req;
        s_req:  if (instr_ack_i) state_r <= s_wait;
        s_wait: if (!instr_ack_i) state_r <= (count_r != '0) ? s_req : s_idle;
        default: state_r <= s_idle;
      endcase
    end
  end

  // head entry shown to decode
  // compressed entries arrive already zero padded from the realigner
  assign head_c             = mem_c[rd_ptr_r];
  assign instr_req_o        = (state_r == s_req);
  assign instr_pc_o         = mem_pc[rd_ptr_r];
  assign instr_compressed_o = head_c;
  assign instr_o            = mem_instr[rd_ptr_r];

endmodule

// ==== verilog/fe_realign_top.sv ====
// fetch realign back end top
// word capture, realigner and output queue in a chain

`timescale 1ns/1ps

module fe_realign_top (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // memory side
  input  logic                            fetch_req_i,
  input  logic [fe_pkg::vaddr_width-1:0]  fetch_pc_i,
  input  logic [fe_pkg::instr_width-1:0]  fetch_data_i,
  output logic                            fetch_ack_o,

  input  logic                            redirect_v_i,

  // decode side
  output logic                            instr_req_o,
  output logic [fe_pkg::instr_width-1:0]  instr_o,
  output logic [fe_pkg::vaddr_width-1:0]  instr_pc_o,
  output logic                            instr_compressed_o,
  input  logic                            instr_ack_i
);

  // capture to realigner
  logic                           word_v;
  logic [fe_pkg::vaddr_width-1:0] word_pc;
  logic [fe_pkg::instr_width-1:0] word_data;
  logic                           word_yumi;

  // realigner to queue
  logic                           instr_v;
  logic [fe_pkg::instr_width-1:0] instr;
  logic [fe_pkg::vaddr_width-1:0] instr_pc;
  logic                           instr_compressed;
  logic                           queue_ready;

  fe_word_capture u_capture (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .fetch_req_i  (fetch_req_i),
    .fetch_pc_i   (fetch_pc_i),
    .fetch_data_i (fetch_data_i),
    .fetch_ack_o  (fetch_ack_o),
    .redirect_v_i (redirect_v_i),
    .word_v_o     (word_v),
    .word_pc_o    (word_pc),
    .word_data_o  (word_data),
    .word_yumi_i  (word_yumi)
  );

  fe_realigner u_realigner (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .word_v_i           (word_v),
    .word_pc_i          (word_pc),
    .word_data_i        (word_data),
    .word_yumi_o        (word_yumi),
    .redirect_v_i       (redirect_v_i),
    .instr_v_o          (instr_v),
    .instr_o            (instr),
    .instr_pc_o         (instr_pc),
    .instr_compressed_o (instr_compressed),
    .queue_ready_i      (queue_ready)
  );

  fe_instr_queue u_queue (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .instr_v_i          (instr_v),
    .instr_i            (instr),
    .instr_pc_i         (instr_pc),
    .instr_compressed_i (instr_compressed),
    .queue_ready_o      (queue_ready),
    .instr_req_o        (instr_req_o),
    .instr_o            (instr_o),
    .instr_pc_o         (instr_pc_o),
    .instr_compressed_o (instr_compressed_o),
    .instr_ack_i        (instr_ack_i)
  );

endmodule

// ==== bench/fe_realign_tb.sv ====
// testbench for the fetch realign back end
// plays word and redirect records from a data file, acks decode outputs
// after a random delay and checks them against the expected list

`timescale 1ns/1ps

module fe_realign_tb;

  localparam int max_recs = 128;

  logic                           clk_i = 1'b0;
  logic                           rst_n_i;
  logic                           fetch_req_i;
  logic [fe_pkg::vaddr_width-1:0] fetch_pc_i;
  logic [fe_pkg::instr_width-1:0] fetch_data_i;
  logic                           fetch_ack_o;
  logic                           redirect_v_i;
  logic                           instr_req_o;
  logic [fe_pkg::instr_width-1:0] instr_o;
  logic [fe_pkg::vaddr_width-1:0] instr_pc_o;
  logic                           instr_compressed_o;
  logic                           instr_ack_i;

  // W and R records, with the number of outputs expected before each
  logic [7:0]                     rec_kind  [max_recs];
  logic [fe_pkg::vaddr_width-1:0] rec_pc    [max_recs];
  logic [fe_pkg::instr_width-1:0] rec_data  [max_recs];
  int                             rec_prior [max_recs];
  int                             n_recs = 0;

  // expected decode outputs in order
  logic [fe_pkg::vaddr_width-1:0] exp_pc    [max_recs];
  logic [fe_pkg::instr_width-1:0] exp_instr [max_recs];
  logic                           exp_c     [max_recs];
  int                             n_exp = 0;

  int n_seen      = 0;
  int n_checks    = 0;
  int value_errs  = 0;
  int other_errs  = 0;
  int cycles      = 0;
  int cycle_limit = 100000;

  always #4 clk_i = ~clk_i;

  fe_realign_top dut (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .fetch_req_i        (fetch_req_i),
    .fetch_pc_i         (fetch_pc_i),
    .fetch_data_i       (fetch_data_i),
    .fetch_ack_o        (fetch_ack_o),
    .redirect_v_i       (redirect_v_i),
    .instr_req_o        (instr_req_o),
    .instr_o            (instr_o),
    .instr_pc_o         (instr_pc_o),
    .instr_compressed_o (instr_compressed_o),
    .instr_ack_i        (instr_ack_i)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      value_errs++;
      $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic load_tests(output bit ok);
    int               fd;
    int               code;
    logic [7:0]       kind;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      c;
    logic [8*160-1:0] skip;
    ok = 1'b0;
    fd = $fopen("bench/fe_realign_tests.txt", "r");
    if (fd != 0) begin
      while ($fscanf(fd, " %c", kind) == 1) begin
        if (kind == "#") begin
          code = $fgets(skip, fd);
        end else if (kind == "E") begin
          code = $fscanf(fd, "%h %h %h", a, b, c);
          exp_pc[n_exp]    = a;
          exp_instr[n_exp] = b;
          exp_c[n_exp]     = c[0];
          n_exp++;
        end else begin
          // W carries pc and data, R only a target pc
          code = (kind == "W") ? $fscanf(fd, "%h %h", a, b) : $fscanf(fd, "%h", a);
          rec_kind[n_recs]  = kind;
          rec_pc[n_recs]    = a;
          rec_data[n_recs]  = b;
          rec_prior[n_recs] = n_exp;
          n_recs++;
        end
      end
      $fclose(fd);
      ok = (n_exp > 0);
    end
  endtask

  // four-phase source, ack comes late while capture still holds a word
  task automatic send_word(input logic [31:0] pc, input logic [31:0] data);
    @(posedge clk_i);
    #1;
    fetch_pc_i   = pc;
    fetch_data_i = data;
    fetch_req_i  = 1'b1;
    while (!fetch_ack_o) begin
      @(posedge clk_i);
      #1;
    end
    fetch_req_i = 1'b0;
    while (fetch_ack_o) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // redirect only once earlier words have drained to decode
  task automatic pulse_redirect(input int prior);
    while (n_seen < prior) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
    redirect_v_i = 1'b1;
    @(posedge clk_i);
    #1;
    redirect_v_i = 1'b0;
  endtask

  initial begin : main
    bit loaded;
    fetch_req_i  = 1'b0;
    fetch_pc_i   = '0;
    fetch_data_i = '0;
    redirect_v_i = 1'b0;
    instr_ack_i  = 1'b0;
    rst_n_i      = 1'b0;
    load_tests(loaded);
    if (!loaded) begin
      $display("could not read expected outputs from bench/fe_realign_tests.txt");
      $display("** FAIL **");
      $finish;
    end else begin
      cycle_limit = 40 * (n_recs + n_exp) + 50 * fe_pkg::queue_depth;
      repeat (5) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      for (int i = 0; i < n_recs; i++) begin
        if (rec_kind[i] == "W") begin
          send_word(rec_pc[i], rec_data[i]);
        end else begin
          pulse_redirect(rec_prior[i]);
        end
      end
      while (n_seen < n_exp) begin
        @(posedge clk_i);
      end
      // leave room for a stray extra output
      repeat (20) @(posedge clk_i);
      if (n_seen != n_exp) begin
        other_errs++;
        $display("saw %0d outputs but %0d were expected", n_seen, n_exp);
      end
      $display("checks %0d, value errors %0d, other errors %0d",
               n_checks, value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

  // decode side, random ack delay lets the queue fill up
  initial begin : consumer
    int delay;
    delay = $urandom(74483);
    wait (rst_n_i === 1'b1);
    forever begin
      @(posedge clk_i);
      #1;
      if (instr_req_o && !instr_ack_i) begin
        if (n_seen >= n_exp) begin
          other_errs++;
          $display("output at pc %h arrived with no expected entry", instr_pc_o);
        end else begin
          check_value("instr_o", exp_instr[n_seen], instr_o);
          check_value("instr_pc_o", exp_pc[n_seen], instr_pc_o);
          check_value("instr_compressed_o", exp_c[n_seen], instr_compressed_o);
        end
        n_seen++;
        delay = $urandom % 6;
        repeat (delay) begin
          @(posedge clk_i);
          #1;
        end
        instr_ack_i = 1'b1;
        while (instr_req_o) begin
          @(posedge clk_i);
          #1;
        end
        instr_ack_i = 1'b0;
      end
    end
  end

  // cycle limit scales with the number of records
  initial begin : watchdog
    while (cycles < cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d of %0d outputs received",
             cycles, n_seen, n_exp);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== build.f ====
verilog/fe_pkg.sv
verilog/fe_word_capture.sv
verilog/fe_realigner.sv
verilog/fe_instr_queue.sv
verilog/fe_realign_top.sv
bench/fe_realign_tb.sv

// ==== bench/fe_realign_tests.txt ====
# W pc data = send a fetch word, R pc = redirect
# E pc instr compressed = next instruction expected at decode, in order
W 00001000 00500093
E 00001000 00500093 0
W 00001004 00a00113
E 00001004 00a00113 0
W 00001008 01134505
E 00001008 00004505 1
W 0000100c 02930020
E 0000100a 00200113 0
W 00001010 80820030
E 0000100e 00300293 0
E 00001012 00008082 1
W 00001016 45011234
E 00001016 00004501 1
W 0000101a 0393ffff
W 0000101c 45050070
E 0000101a 00700393 0
E 0000101e 00004505 1
W 00001020 04134511
E 00001020 00004511 1
R 00002000
W 00002000 00100513
E 00002000 00100513 0
W 00002006 0593aaaa
R 00003000
W 00003000 45814501
E 00003000 00004501 1
E 00003002 00004581 1
W 00003004 c6068082
E 00003004 00008082 1
E 00003006 0000c606 1
W 00003008 11414505
E 00003008 00004505 1
E 0000300a 00001141 1
